// File: design/dx_if.sv
// Dispatch to execute channel, one micro-op per val/rdy transfer.
// src side drives the micro-op, dst side answers with rdy.

`default_nettype none

interface dx_if;

  logic                          val;
  logic                          rdy;
  logic [exec_pkg::XLEN-1:0]     pc;
  logic [exec_pkg::SEQ_BITS-1:0] seq_num; // Lets consumer reorder
  logic [exec_pkg::XLEN-1:0]     op1;
  logic [exec_pkg::XLEN-1:0]     op2;
  logic [exec_pkg::REG_BITS-1:0] waddr;
  exec_pkg::uop_e                uop;

  modport src (output val, pc, seq_num, op1, op2, waddr, uop, input rdy);
  modport dst (input val, pc, seq_num, op1, op2, waddr, uop, output rdy);

endinterface

`default_nettype wire

// File: design/exec_dispatch.sv
// Steers each micro-op to the ALU or the multiplier, no latency.
// Ready comes back only from the unit that would take the micro-op.

`default_nettype none

module exec_dispatch (
  dx_if.dst d,
  dx_if.src alu,
  dx_if.src mul
);

  logic is_mul;

  assign is_mul = (d.uop == exec_pkg::OP_MUL) || (d.uop == exec_pkg::OP_MULHU);

  // Valid to the selected unit only
  assign alu.val = d.val & !is_mul;
  assign mul.val = d.val & is_mul;

  // Payload fans out to both
  assign alu.pc      = d.pc;
  assign alu.seq_num = d.seq_num;
  assign alu.op1     = d.op1;
  assign alu.op2     = d.op2;
  assign alu.waddr   = d.waddr;
  assign alu.uop     = d.uop;
  assign mul.pc      = d.pc;
  assign mul.seq_num = d.seq_num;
  assign mul.op1     = d.op1;
  assign mul.op2     = d.op2;
  assign mul.waddr   = d.waddr;
  assign mul.uop     = d.uop;

  assign d.rdy = is_mul ? mul.rdy : alu.rdy; // Busy unit blocks only its own ops

endmodule

`default_nettype wire

// File: design/exec_pkg.sv
// Shared widths, stage count and enums for the execute cluster.
// Every design file refers to these by scoped name (exec_pkg::...).

`default_nettype none

package exec_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  localparam int XLEN     = 32; // Operand and data width
  localparam int SEQ_BITS = 8;  // Sequence number width
  localparam int REG_BITS = 5;  // Register address width

  localparam int MUL_STAGES = 3; // Default multiplier latency

  // ----------------------------------------
  // Enums
  // ----------------------------------------

  // Encodings match the hex opcodes in the test file
  typedef enum logic [3:0] {
    OP_ADD   = 4'h0,
    OP_SUB   = 4'h1,
    OP_AND   = 4'h2,
    OP_OR    = 4'h3,
    OP_XOR   = 4'h4,
    OP_SLTU  = 4'h5,
    OP_MUL   = 4'h6, // Low half of product
    OP_MULHU = 4'h7  // High half, unsigned
  } uop_e;

  typedef enum logic {
    OWNER_ALU = 1'b0,
    OWNER_MUL = 1'b1
  } owner_e;

endpackage

`default_nettype wire

// File: design/execute_top.sv
// Execute cluster top level. Plain dispatch ports in, plain writeback
// ports out; units talk over internal val/rdy interfaces.

`default_nettype none

module execute_top (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          d_val,
  output      logic                          d_rdy,
  input  wire logic [exec_pkg::XLEN-1:0]     d_pc,
  input  wire logic [exec_pkg::SEQ_BITS-1:0] d_seq_num,
  input  wire logic [exec_pkg::XLEN-1:0]     d_op1,
  input  wire logic [exec_pkg::XLEN-1:0]     d_op2,
  input  wire logic [exec_pkg::REG_BITS-1:0] d_waddr,
  input  wire exec_pkg::uop_e                d_uop,
  output      logic                          w_val,
  input  wire logic                          w_rdy,
  output      logic [exec_pkg::XLEN-1:0]     w_pc,
  output      logic [exec_pkg::SEQ_BITS-1:0] w_seq_num,
  output      logic [exec_pkg::REG_BITS-1:0] w_waddr,
  output      logic [exec_pkg::XLEN-1:0]     w_wdata,
  output      logic                          w_wen
);

  dx_if d_bus ();
  dx_if alu_bus ();
  dx_if mul_bus ();
  xw_if alu_wb ();
  xw_if mul_wb ();

  // Dispatch ports onto the internal channel
  assign d_bus.val     = d_val;
  assign d_bus.pc      = d_pc;
  assign d_bus.seq_num = d_seq_num;
  assign d_bus.op1     = d_op1;
  assign d_bus.op2     = d_op2;
  assign d_bus.waddr   = d_waddr;
  assign d_bus.uop     = d_uop;
  assign d_rdy         = d_bus.rdy;

  exec_dispatch u_dispatch (.d(d_bus), .alu(alu_bus), .mul(mul_bus));

  int_alu u_alu (.clk, .rst, .d(alu_bus), .w(alu_wb));

  pipelined_multiplier #(
    .num_stages(exec_pkg::MUL_STAGES)
  ) u_mul (.clk, .rst, .d(mul_bus), .w(mul_wb));

  wb_arbiter u_arb (
    .clk, .rst,
    .alu(alu_wb), .mul(mul_wb),
    .w_val, .w_rdy, .w_pc, .w_seq_num, .w_waddr, .w_wdata, .w_wen
  );

endmodule

`default_nettype wire

// File: design/int_alu.sv
// Single-cycle integer ALU with one registered result slot.
// Result shows on w the cycle after accept; slot refills while draining.

`default_nettype none

module int_alu (
  input wire logic clk,
  input wire logic rst,
  dx_if.dst        d,
  xw_if.src        w
);

  logic                      slot_val;
  logic [exec_pkg::XLEN-1:0] result;

  assign d.rdy = !slot_val | w.rdy; // Empty or result leaving

  // ----------------------------------------
  // Operations
  // ----------------------------------------

  always_comb begin
    case (d.uop)
      exec_pkg::OP_ADD:  result = d.op1 + d.op2;
      exec_pkg::OP_SUB:  result = d.op1 - d.op2; // Wraps mod 2^32
      exec_pkg::OP_AND:  result = d.op1 & d.op2;
      exec_pkg::OP_OR:   result = d.op1 | d.op2;
      exec_pkg::OP_XOR:  result = d.op1 ^ d.op2;
      exec_pkg::OP_SLTU: result = {{(exec_pkg::XLEN-1){1'b0}}, (d.op1 < d.op2)};
      default:           result = '0; // Multiplies never steered here
    endcase
  end

  // ----------------------------------------
  // Result slot
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_val <= 1'b0;
    end else if (d.val && d.rdy) begin
      slot_val <= 1'b1;
    end else if (w.rdy) begin
      slot_val <= 1'b0; // Drained with nothing behind it
    end
  end

  always_ff @(posedge clk) begin
    if (d.val && d.rdy) begin
      w.pc      <= d.pc;
      w.seq_num <= d.seq_num;
      w.waddr   <= d.waddr;
      w.wdata   <= result;
    end
  end

  assign w.val = slot_val;

endmodule

`default_nettype wire

// File: design/pipelined_multiplier.sv
// Unsigned multiplier with num_stages cycles of latency (minimum 1).
// Input register, then a chain of elastic output stages; each stage
// accepts when the stage after it is empty or draining.

`default_nettype none

module pipelined_multiplier #(
  parameter int num_stages = exec_pkg::MUL_STAGES
) (
  input wire logic clk,
  input wire logic rst,
  dx_if.dst        d,
  xw_if.src        w
);

  typedef struct packed {
    logic [exec_pkg::XLEN-1:0]     pc;
    logic [exec_pkg::SEQ_BITS-1:0] seq_num;
    logic [exec_pkg::REG_BITS-1:0] waddr;
    logic [exec_pkg::XLEN-1:0]     wdata;
  } result_t;

  // ----------------------------------------
  // Input register
  // ----------------------------------------

  logic                          in_val;
  logic [exec_pkg::XLEN-1:0]     in_pc;
  logic [exec_pkg::SEQ_BITS-1:0] in_seq_num;
  logic [exec_pkg::XLEN-1:0]     in_op1;
  logic [exec_pkg::XLEN-1:0]     in_op2;
  logic [exec_pkg::REG_BITS-1:0] in_waddr;
  exec_pkg::uop_e                in_uop;

  logic [2*exec_pkg::XLEN-1:0]   product;

  // One entry per stage; entry 0 is the input register's result
  logic    stage_val [num_stages];
  result_t stage_data [num_stages];
  logic    stage_rdy [num_stages];

  assign d.rdy = stage_rdy[0] | !in_val; // Empty or draining

  always_ff @(posedge clk) begin
    if (rst) begin
      in_val <= 1'b0;
    end else if (d.val && d.rdy) begin
      in_val <= 1'b1;
    end else if (in_val && stage_rdy[0]) begin
      in_val <= 1'b0; // Left for next stage
    end
  end

  always_ff @(posedge clk) begin
    if (d.val && d.rdy) begin // Payload, loaded on accept only
      in_pc      <= d.pc;
      in_seq_num <= d.seq_num;
      in_op1     <= d.op1;
      in_op2     <= d.op2;
      in_waddr   <= d.waddr;
      in_uop     <= d.uop;
    end
  end

  // ----------------------------------------
  // Multiply
  // ----------------------------------------

  // Zero extend both operands for the full unsigned product
  assign product = {{exec_pkg::XLEN{1'b0}}, in_op1} * {{exec_pkg::XLEN{1'b0}}, in_op2};

  assign stage_val[0]          = in_val;
  assign stage_data[0].pc      = in_pc;
  assign stage_data[0].seq_num = in_seq_num;
  assign stage_data[0].waddr   = in_waddr;
  assign stage_data[0].wdata   = (in_uop == exec_pkg::OP_MULHU) ?
                                 product[2*exec_pkg::XLEN-1:exec_pkg::XLEN] : // High half
                                 product[exec_pkg::XLEN-1:0];

  // ----------------------------------------
  // Output stages
  // ----------------------------------------

  assign stage_rdy[num_stages-1] = w.rdy; // Last stage faces writeback

  for (genvar i = 1; i < num_stages; i++) begin : g_stage
    always_ff @(posedge clk) begin
      if (rst) begin
        stage_val[i] <= 1'b0;
      end else if (stage_val[i-1] && stage_rdy[i-1]) begin
        stage_val[i] <= 1'b1;
      end else if (stage_val[i] && stage_rdy[i]) begin
        stage_val[i] <= 1'b0;
      end
    end

    always_ff @(posedge clk) begin
      if (stage_val[i-1] && stage_rdy[i-1]) stage_data[i] <= stage_data[i-1];
    end

    assign stage_rdy[i-1] = stage_rdy[i] | !stage_val[i]; // Next ready or empty
  end

  assign w.val     = stage_val[num_stages-1];
  assign w.pc      = stage_data[num_stages-1].pc;
  assign w.seq_num = stage_data[num_stages-1].seq_num;
  assign w.waddr   = stage_data[num_stages-1].waddr;
  assign w.wdata   = stage_data[num_stages-1].wdata;

endmodule

`default_nettype wire

// File: design/wb_arbiter.sv
// Round-robin merge of ALU and multiplier results onto one writeback port.
// A grant held under a stall stays put until the transfer completes.

`default_nettype none

module wb_arbiter (
  input  wire logic                          clk,
  input  wire logic                          rst,
  xw_if.dst                                  alu,
  xw_if.dst                                  mul,
  output      logic                          w_val,
  input  wire logic                          w_rdy,
  output      logic [exec_pkg::XLEN-1:0]     w_pc,
  output      logic [exec_pkg::SEQ_BITS-1:0] w_seq_num,
  output      logic [exec_pkg::REG_BITS-1:0] w_waddr,
  output      logic [exec_pkg::XLEN-1:0]     w_wdata,
  output      logic                          w_wen
);

  exec_pkg::owner_e owner; // Last unit to transfer
  logic hold;              // Stalled last cycle, keep grant
  logic hold_mul;
  logic pick_mul;
  logic alu_gnt;
  logic mul_gnt;

  // Not the owner wins a tie
  assign pick_mul = hold ? hold_mul :
                    (mul.val & (!alu.val | (owner == exec_pkg::OWNER_ALU)));
  assign alu_gnt  = alu.val & !pick_mul;
  assign mul_gnt  = mul.val & pick_mul;

  assign alu.rdy = w_rdy & alu_gnt;
  assign mul.rdy = w_rdy & mul_gnt;

  // ----------------------------------------
  // Output mux
  // ----------------------------------------

  assign w_val     = alu_gnt | mul_gnt;
  assign w_pc      = mul_gnt ? mul.pc      : alu.pc;
  assign w_seq_num = mul_gnt ? mul.seq_num : alu.seq_num;
  assign w_waddr   = mul_gnt ? mul.waddr   : alu.waddr;
  assign w_wdata   = mul_gnt ? mul.wdata   : alu.wdata;
  assign w_wen     = w_val & (w_waddr != '0); // x0 never written

  always_ff @(posedge clk) begin
    if (rst) begin
      owner    <= exec_pkg::OWNER_ALU;
      hold     <= 1'b0;
      hold_mul <= 1'b0;
    end else begin
      if (w_val && w_rdy) owner <= mul_gnt ? exec_pkg::OWNER_MUL : exec_pkg::OWNER_ALU;
      hold     <= w_val & !w_rdy;
      hold_mul <= mul_gnt;
    end
  end

endmodule

`default_nettype wire

// File: design/xw_if.sv
// Execute to writeback channel carrying one result per transfer.
// Same val/rdy rule as the dispatch channel.

`default_nettype none

interface xw_if;

  logic                          val;
  logic                          rdy;
  logic [exec_pkg::XLEN-1:0]     pc;
  logic [exec_pkg::SEQ_BITS-1:0] seq_num;
  logic [exec_pkg::REG_BITS-1:0] waddr;
  logic [exec_pkg::XLEN-1:0]     wdata;

  // Producer side
  modport src (output val, pc, seq_num, waddr, wdata, input rdy);

  // Consumer side
  modport dst (input val, pc, seq_num, waddr, wdata, output rdy);

endinterface

`default_nettype wire

// File: execute_top.f
design/exec_pkg.sv
design/dx_if.sv
design/xw_if.sv
design/exec_dispatch.sv
design/int_alu.sv
design/pipelined_multiplier.sv
design/wb_arbiter.sv
design/execute_top.sv
sim/clock_gen.sv
sim/execute_asserts.sv
sim/execute_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute cluster testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module execute_tb -f execute_top.f -o execute_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/execute_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// File: sim/clock_gen.sv
// Testbench clock and reset source for the execute cluster.
// 40 ns period; reset held high for the first 10 rising edges.

`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // Half period
  end

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk); // Release away from the sampling edge
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: sim/execute_asserts.sv
// Handshake checks on the execute cluster top level.
// Bound to execute_top below, so every instance gets them.

`default_nettype none

module execute_asserts (
  input wire logic                          clk,
  input wire logic                          rst,
  input wire logic                          d_val,
  input wire logic                          d_rdy,
  input wire logic [exec_pkg::XLEN-1:0]     d_pc,
  input wire logic [exec_pkg::SEQ_BITS-1:0] d_seq_num,
  input wire logic [exec_pkg::XLEN-1:0]     d_op1,
  input wire logic [exec_pkg::XLEN-1:0]     d_op2,
  input wire logic [exec_pkg::REG_BITS-1:0] d_waddr,
  input wire exec_pkg::uop_e                d_uop,
  input wire logic                          w_val,
  input wire logic                          w_rdy,
  input wire logic [exec_pkg::XLEN-1:0]     w_pc,
  input wire logic [exec_pkg::SEQ_BITS-1:0] w_seq_num,
  input wire logic [exec_pkg::REG_BITS-1:0] w_waddr,
  input wire logic [exec_pkg::XLEN-1:0]     w_wdata,
  input wire logic                          w_wen
);
  timeunit 1ns;
  timeprecision 1ps;

  // Stalled dispatch keeps its micro-op
  a_d_stable: assert property (@(posedge clk) disable iff (rst)
    d_val && !d_rdy |=> d_val && $stable({d_pc, d_seq_num, d_op1, d_op2, d_waddr, d_uop}))
    else $error("Dispatch fields changed during a stall");

  // Stalled writeback keeps its result
  a_w_stable: assert property (@(posedge clk) disable iff (rst)
    w_val && !w_rdy |=> w_val && $stable({w_pc, w_seq_num, w_waddr, w_wdata}))
    else $error("Writeback fields changed during a stall");

  a_rst_quiet: assert property (@(posedge clk) rst |=> !w_val && !w_wen)
    else $error("Writeback valid right after a reset cycle");

  a_wen_val: assert property (@(posedge clk) disable iff (rst) w_wen |-> w_val)
    else $error("Write enable without valid");

endmodule

bind execute_top execute_asserts u_asserts (
  .clk(clk), .rst(rst),
  .d_val(d_val), .d_rdy(d_rdy), .d_pc(d_pc), .d_seq_num(d_seq_num),
  .d_op1(d_op1), .d_op2(d_op2), .d_waddr(d_waddr), .d_uop(d_uop),
  .w_val(w_val), .w_rdy(w_rdy), .w_pc(w_pc), .w_seq_num(w_seq_num),
  .w_waddr(w_waddr), .w_wdata(w_wdata), .w_wen(w_wen)
);

`default_nettype wire

// File: sim/execute_tb.sv
// Testbench for execute_top. Reads micro-ops from sim/execute_tests.txt,
// drives dispatch on the falling edge under random writeback stalls, and
// checks each result by sequence number. Last two lines run unstalled.

`default_nettype none

module execute_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_TESTS = 2 ** exec_pkg::SEQ_BITS; // One slot per seq_num
  localparam int QUIET_OPS = 2;                        // Latency section at file end

  logic                          clk;
  logic                          rst;
  logic                          d_val;
  logic                          d_rdy;
  logic [exec_pkg::XLEN-1:0]     d_pc;
  logic [exec_pkg::SEQ_BITS-1:0] d_seq_num;
  logic [exec_pkg::XLEN-1:0]     d_op1;
  logic [exec_pkg::XLEN-1:0]     d_op2;
  logic [exec_pkg::REG_BITS-1:0] d_waddr;
  exec_pkg::uop_e                d_uop;
  logic                          w_val;
  logic                          w_rdy;
  logic [exec_pkg::XLEN-1:0]     w_pc;
  logic [exec_pkg::SEQ_BITS-1:0] w_seq_num;
  logic [exec_pkg::REG_BITS-1:0] w_waddr;
  logic [exec_pkg::XLEN-1:0]     w_wdata;
  logic                          w_wen;

  logic [31:0]                   tests_mem [4*MAX_TESTS]; // 4 words per micro-op
  logic [exec_pkg::XLEN-1:0]     exp_data  [MAX_TESTS];
  logic [exec_pkg::XLEN-1:0]     exp_pc    [MAX_TESTS];
  logic [exec_pkg::REG_BITS-1:0] exp_waddr [MAX_TESTS];
  bit                            seen      [MAX_TESTS];
  int                            acc_cycle [MAX_TESTS];
  int                            ret_cycle [MAX_TESTS];

  int     n_tests;
  int     n_issued;
  int     n_seen;
  int     mismatch_count;
  int     other_count;
  int     cycle;
  int     cycle_limit;
  integer seed;
  bit     quiet; // Hold w_rdy high

  clock_gen u_clk (.clk(clk), .rst(rst));

  execute_top UUT (
    .clk, .rst, .d_val, .d_rdy, .d_pc, .d_seq_num, .d_op1, .d_op2, .d_waddr, .d_uop,
    .w_val, .w_rdy, .w_pc, .w_seq_num, .w_waddr, .w_wdata, .w_wen
  );

  // ----------------------------------------
  // Reference model and compares
  // ----------------------------------------

  function automatic exec_pkg::uop_e test_uop(input int idx);
    return exec_pkg::uop_e'(tests_mem[4*idx][3:0]);
  endfunction

  function automatic logic [exec_pkg::XLEN-1:0] expected_result(
    input exec_pkg::uop_e op, input logic [exec_pkg::XLEN-1:0] a, input logic [exec_pkg::XLEN-1:0] b
  );
    logic [2*exec_pkg::XLEN-1:0] prod;
    logic [exec_pkg::XLEN-1:0]   r;
    prod = (2*exec_pkg::XLEN)'(a) * (2*exec_pkg::XLEN)'(b); // Unsigned full product
    r    = '0;
    case (op)
      exec_pkg::OP_ADD:   r = a + b;
      exec_pkg::OP_SUB:   r = a - b;
      exec_pkg::OP_AND:   r = a & b;
      exec_pkg::OP_OR:    r = a | b;
      exec_pkg::OP_XOR:   r = a ^ b;
      exec_pkg::OP_SLTU:  r[0] = (a < b);
      exec_pkg::OP_MUL:   r = prod[exec_pkg::XLEN-1:0];
      exec_pkg::OP_MULHU: r = prod[2*exec_pkg::XLEN-1:exec_pkg::XLEN];
      default:            r = '0;
    endcase
    return r;
  endfunction

  task automatic check_data(input logic [exec_pkg::SEQ_BITS-1:0] seq,
                            input logic [exec_pkg::XLEN-1:0] wdata,
                            input logic [exec_pkg::REG_BITS-1:0] waddr);
    if (wdata !== exp_data[seq]) begin
      mismatch_count++;
      $display("MISMATCH at %0t: seq %0d wdata %h, expected %h", $time, seq, wdata, exp_data[seq]);
    end
    if (waddr !== exp_waddr[seq]) begin
      mismatch_count++;
      $display("MISMATCH at %0t: seq %0d waddr %0d, expected %0d",
               $time, seq, waddr, exp_waddr[seq]);
    end
  endtask

  task automatic check_pc(input logic [exec_pkg::SEQ_BITS-1:0] seq,
                          input logic [exec_pkg::XLEN-1:0] pc);
    if (pc !== exp_pc[seq]) begin
      mismatch_count++;
      $display("MISMATCH at %0t: seq %0d pc %h, expected %h", $time, seq, pc, exp_pc[seq]);
    end
  endtask

  task automatic check_wen(input logic [exec_pkg::SEQ_BITS-1:0] seq, input logic wen);
    logic exp_wen;
    exp_wen = (exp_waddr[seq] != '0); // x0 writes suppressed
    if (wen !== exp_wen) begin
      mismatch_count++;
      $display("MISMATCH at %0t: seq %0d w_wen %b, expected %b", $time, seq, wen, exp_wen);
    end
  endtask

  task automatic check_latency(input logic [exec_pkg::SEQ_BITS-1:0] seq,
                               input int got, input int want);
    if (got != want) begin
      mismatch_count++;
      $display("MISMATCH at %0t: seq %0d latency %0d cycles, expected %0d",
               $time, seq, got, want);
    end
  endtask

  task automatic report_missing();
    for (int i = 0; i < n_issued; i++) begin
      if (!seen[i]) begin
        other_count++;
        $display("Sequence number %0d was issued but never written back", i);
      end
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
  endtask

  // ----------------------------------------
  // Dispatch driver
  // ----------------------------------------

  task automatic issue(input int idx);
    @(negedge clk);
    d_val     = 1'b1;
    d_pc      = exp_pc[idx];
    d_seq_num = idx[exec_pkg::SEQ_BITS-1:0];
    d_op1     = tests_mem[4*idx+1];
    d_op2     = tests_mem[4*idx+2];
    d_waddr   = exp_waddr[idx];
    d_uop     = test_uop(idx);
    do @(posedge clk); while (!d_rdy); // Fields held through the stall
    acc_cycle[idx] = cycle;
    n_issued++;
  endtask

  task automatic wait_drain();
    while (n_seen < n_issued) @(posedge clk);
  endtask

  initial begin : stimulus
    exec_pkg::uop_e op;
    int             want;
    d_val = 1'b0;
    d_pc = '0;
    d_seq_num = '0;
    d_op1 = '0;
    d_op2 = '0;
    d_waddr = '0;
    d_uop = exec_pkg::OP_ADD;
    quiet = 1'b0;
    n_issued = 0;
    n_seen = 0;
    mismatch_count = 0;
    other_count = 0;
    cycle_limit = 0;
    for (int i = 0; i < 4*MAX_TESTS; i++) tests_mem[i] = 32'hffff_0000 | i; // ffff over index
    $readmemh("sim/execute_tests.txt", tests_mem);
    n_tests = 0;
    while (n_tests < MAX_TESTS && tests_mem[4*n_tests][31:16] != 16'hffff) n_tests++;
    if (n_tests <= QUIET_OPS) begin
      other_count++;
      $display("Tests file holds only %0d micro-ops, too few to run", n_tests);
    end
    for (int i = 0; i < n_tests; i++) begin
      seen[i]      = 1'b0;
      exp_pc[i]    = 4 * i;
      exp_waddr[i] = tests_mem[4*i+3][exec_pkg::REG_BITS-1:0];
      exp_data[i]  = expected_result(test_uop(i), tests_mem[4*i+1], tests_mem[4*i+2]);
    end
    cycle_limit = n_tests * (exec_pkg::MUL_STAGES + 8) + 100;
    @(negedge rst);
    // Back to back under random stalls
    for (int i = 0; i < n_tests - QUIET_OPS; i++) issue(i);
    @(negedge clk) d_val = 1'b0;
    wait_drain();
    quiet = 1'b1;
    @(negedge clk);
    // Lone ops for latency
    for (int i = n_tests - QUIET_OPS; i < n_tests; i++) begin
      wait_drain();
      issue(i);
      @(negedge clk) d_val = 1'b0;
    end
    wait_drain();
    repeat (20) @(negedge clk); // Room for a stray duplicate
    for (int i = n_tests - QUIET_OPS; i < n_tests; i++) begin
      op   = test_uop(i);
      want = (op == exec_pkg::OP_MUL || op == exec_pkg::OP_MULHU) ? exec_pkg::MUL_STAGES : 1;
      if (seen[i]) check_latency(i[exec_pkg::SEQ_BITS-1:0], ret_cycle[i] - acc_cycle[i], want);
    end
    report_counts();
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Writeback stalls about a quarter of the time
  initial begin : backpressure
    seed  = 32'hc855;
    w_rdy = 1'b0;
    forever begin
      @(negedge clk);
      w_rdy = quiet ? 1'b1 : (($random(seed) & 3) != 0);
    end
  end

  // ----------------------------------------
  // Writeback monitor and watchdog
  // ----------------------------------------

  always @(posedge clk) begin
    if (!rst && w_val && w_rdy) begin
      if (int'(w_seq_num) >= n_tests) begin
        other_count++;
        $display("Writeback of sequence number %0d, which was never issued", w_seq_num);
      end else if (seen[w_seq_num]) begin
        other_count++;
        $display("Sequence number %0d written back a second time", w_seq_num);
      end else begin
        seen[w_seq_num]      = 1'b1;
        ret_cycle[w_seq_num] = cycle;
        n_seen++;
        check_data(w_seq_num, w_wdata, w_waddr);
        check_pc(w_seq_num, w_pc);
        check_wen(w_seq_num, w_wen);
      end
    end
  end

  initial begin : watchdog
    cycle = 0;
    while (cycle_limit == 0 || cycle < cycle_limit) begin
      @(posedge clk);
      cycle <= cycle + 1;
    end
    $display("Timeout after %0d cycles, %0d of %0d results written back", cycle, n_seen, n_tests);
    report_missing();
    report_counts();
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/execute_tests.txt
// Columns: opcode op1 op2 waddr, hex, one micro-op per line
// Opcodes 0 add 1 sub 2 and 3 or 4 xor 5 sltu 6 mul 7 mulhu; last two lines run unstalled
0 00000005 00000007 01
1 00000003 00000005 02
2 f0f0f0f0 ff00ff00 03
3 0f0f0000 000000ff 04
4 aaaaaaaa ffffffff 05
5 00000001 00000002 06
5 80000000 7fffffff 07
6 00001234 00005678 08
7 ffffffff ffffffff 09
6 ffffffff ffffffff 0a
7 12345678 9abcdef0 0b
0 ffffffff 00000001 00
6 00000003 00000004 00
6 00010000 00010000 0c
7 00010000 00010000 0d
1 00000000 00000001 0e
6 deadbeef 00000002 0f
0 00000011 00000022 10
7 80000000 00000004 11
